/* include/rename_defs.svh */
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

// physical register file size, also the free list depth
`define RN_NUM_PHYS 128

// architectural registers own tags 0 .. RN_NUM_ARCH-1 after reset
`define RN_NUM_ARCH 32

// branch checkpoint slots
`define RN_NUM_CKPT 8

// bits in a physical tag, log2 of RN_NUM_PHYS
`define RN_TAG_W 7

`endif

/* src/rename_types_pkg.sv */
`include "rename_defs.svh"

package rename_types_pkg;

    // physical register tag
    typedef logic [`RN_TAG_W-1:0] phys_tag_t;

    // free list pointer, index plus one wrap bit
    typedef logic [`RN_TAG_W:0] fl_ptr_t;

    // free tag count, 0 through RN_NUM_PHYS inclusive
    typedef logic [`RN_TAG_W:0] fl_count_t;

endpackage

/* src/ckpt_pkg.sv */
`include "rename_defs.svh"

package ckpt_pkg;

    // index of one checkpoint slot
    typedef logic [$clog2(`RN_NUM_CKPT)-1:0] ckpt_id_t;

    // one bit per slot, used one-hot for writes
    typedef logic [`RN_NUM_CKPT-1:0] ckpt_sel_t;

endpackage

/* src/ckpt_bank_if.sv */
`timescale 1ns/1ns
`include "rename_defs.svh"

interface ckpt_bank_if;

    ckpt_pkg::ckpt_sel_t       save_sel;                   // one-hot slot write strobe
    rename_types_pkg::fl_ptr_t save_head;                  // head value to store
    rename_types_pkg::fl_ptr_t slot_head [`RN_NUM_CKPT];   // saved head per slot
    logic                      slot_valid [`RN_NUM_CKPT];  // slot written since reset

    modport disp (
        output save_sel,
        output save_head
    );

    modport slot (
        input  save_sel,
        input  save_head,
        output slot_head,
        output slot_valid
    );

    modport sel (
        input slot_head,
        input slot_valid
    );

endinterface

/* src/free_list.sv */
`timescale 1ns/1ns
`include "rename_defs.svh"

module free_list (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          alloc_req,
    input  logic                          release_req,
    input  rename_types_pkg::phys_tag_t   release_tag,
    input  logic                          rewind,
    input  rename_types_pkg::fl_ptr_t     rewind_head,
    output rename_types_pkg::phys_tag_t   alloc_tag,
    output logic                          alloc_ok,
    output rename_types_pkg::fl_ptr_t     head,
    output rename_types_pkg::fl_count_t   free_count
);

    import rename_types_pkg::*;

    phys_tag_t entries [`RN_NUM_PHYS];  // circular tag buffer
    fl_ptr_t   tail;                    // next write position
    logic      do_alloc;

    assign do_alloc = alloc_req && alloc_ok;  // empty list ignores the request

    // tag storage
    // on reset entry i holds tag i+32, so entries 0..95 carry the free tags 32..127
    // and the upper entries wrap to 0..31, which are overwritten before use
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `RN_NUM_PHYS; i++) begin
                entries[i] <= phys_tag_t'(i + `RN_NUM_ARCH);
            end
        end else if (release_req) begin
            entries[tail[`RN_TAG_W-1:0]] <= release_tag;  // retired tag joins at the tail
        end
    end

    // head and tail pointers
    always_ff @(posedge clock) begin
        if (reset) begin
            head <= '0;
            tail <= fl_ptr_t'(`RN_NUM_PHYS - `RN_NUM_ARCH);
        end else begin
            if (rewind) begin
                head <= rewind_head;   // restore wins over allocation
            end else if (do_alloc) begin
                head <= head + fl_ptr_t'(1);
            end
            if (release_req) begin
                tail <= tail + fl_ptr_t'(1);   // tail is never rewound
            end
        end
    end

    // wrap bits make tail - head cover empty (0) through full (128)
    assign free_count = fl_count_t'(tail - head);
    assign alloc_ok   = (free_count != '0);
    assign alloc_tag  = entries[head[`RN_TAG_W-1:0]];  // head entry shown combinationally

endmodule

/* src/ckpt_dispatch.sv */
`timescale 1ns/1ns

module ckpt_dispatch (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        save_state,
    input  ckpt_pkg::ckpt_id_t          save_page,
    input  rename_types_pkg::fl_ptr_t   head,
    input  logic                        rewind,
    input  rename_types_pkg::fl_ptr_t   rewind_head,
    ckpt_bank_if.disp                   bank
);

    import rename_types_pkg::*;
    import ckpt_pkg::*;

    fl_ptr_t snapshot;   // value to record on this save

    // a save taken at a mispredict records the restored head
    assign snapshot = rewind ? rewind_head : head;

    assign bank.save_sel  = save_state ? (ckpt_sel_t'(1) << save_page) : '0;
    assign bank.save_head = snapshot;

endmodule

/* src/ckpt_slot.sv */
`timescale 1ns/1ns

module ckpt_slot #(
    parameter int SLOT_ID = 0  // position in the bank
) (
    input  logic       clock,
    input  logic       reset,
    ckpt_bank_if.slot  bank
);

    import rename_types_pkg::*;

    fl_ptr_t saved_head;   // head pointer at the time of the save
    logic    saved_valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            saved_head  <= '0;
            saved_valid <= 1'b0;
        end else if (bank.save_sel[SLOT_ID]) begin
            saved_head  <= bank.save_head;
            saved_valid <= 1'b1;   // stays set until the next reset
        end
    end

    // each slot drives only its own element of the bank arrays
    assign bank.slot_head[SLOT_ID]  = saved_head;
    assign bank.slot_valid[SLOT_ID] = saved_valid;

endmodule

/* src/ckpt_select.sv */
`timescale 1ns/1ns
`include "rename_defs.svh"

module ckpt_select (
    input  logic                        restore_state,
    input  ckpt_pkg::ckpt_id_t          restore_page,
    ckpt_bank_if.sel                    bank,
    output logic                        rewind,
    output rename_types_pkg::fl_ptr_t   rewind_head
);

    import rename_types_pkg::*;
    import ckpt_pkg::*;

    ckpt_sel_t page_hit;     // one-hot decode of restore_page
    fl_ptr_t   picked_head;
    logic      picked_valid;

    assign page_hit = ckpt_sel_t'(1) << restore_page;

    // and-or mux over the slots
    always_comb begin
        picked_head  = '0;
        picked_valid = 1'b0;
        for (int i = 0; i < `RN_NUM_CKPT; i++) begin
            if (page_hit[i]) begin
                picked_head  = picked_head | bank.slot_head[i];
                picked_valid = picked_valid | bank.slot_valid[i];
            end
        end
    end

    // restore of a slot never saved is dropped here
    assign rewind      = restore_state && picked_valid;
    assign rewind_head = picked_head;

endmodule

/* src/rename_top.sv */
`timescale 1ns/1ns
`include "rename_defs.svh"

module rename_top (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          alloc_req,
    output rename_types_pkg::phys_tag_t   alloc_tag,
    output logic                          alloc_ok,
    input  logic                          release_req,
    input  rename_types_pkg::phys_tag_t   release_tag,
    input  logic                          save_state,
    input  ckpt_pkg::ckpt_id_t            save_page,
    input  logic                          restore_state,
    input  ckpt_pkg::ckpt_id_t            restore_page,
    output rename_types_pkg::fl_count_t   free_count
);

    import rename_types_pkg::*;

    fl_ptr_t head;         // current free list head
    logic    rewind;       // valid restore this cycle
    fl_ptr_t rewind_head;  // head to restore

    ckpt_bank_if bank ();

    free_list u_free_list (
        .clock       (clock),
        .reset       (reset),
        .alloc_req   (alloc_req),
        .release_req (release_req),
        .release_tag (release_tag),
        .rewind      (rewind),
        .rewind_head (rewind_head),
        .alloc_tag   (alloc_tag),
        .alloc_ok    (alloc_ok),
        .head        (head),
        .free_count  (free_count)
    );

    ckpt_dispatch u_ckpt_dispatch (
        .clock       (clock),
        .reset       (reset),
        .save_state  (save_state),
        .save_page   (save_page),
        .head        (head),
        .rewind      (rewind),
        .rewind_head (rewind_head),
        .bank        (bank)
    );

    // one slot per checkpoint page
    for (genvar i = 0; i < `RN_NUM_CKPT; i++) begin : g_slot
        ckpt_slot #(
            .SLOT_ID (i)
        ) u_ckpt_slot (
            .clock (clock),
            .reset (reset),
            .bank  (bank)
        );
    end

    ckpt_select u_ckpt_select (
        .restore_state (restore_state),
        .restore_page  (restore_page),
        .bank          (bank),
        .rewind        (rewind),
        .rewind_head   (rewind_head)
    );

endmodule

/* verif/rename_chk.sv */
`timescale 1ns/1ns
`include "rename_defs.svh"

module rename_chk (
    input logic                        clock,
    input logic                        reset,
    input logic                        alloc_req,
    input logic                        release_req,
    input logic                        restore_state,
    input logic                        alloc_ok,
    input rename_types_pkg::fl_count_t free_count
);

    import rename_types_pkg::*;

    int failures = 0;  // failed assertion count

    // count spans empty through full and never more
    count_in_range: assert property (@(posedge clock) disable iff (reset)
        free_count <= fl_count_t'(`RN_NUM_PHYS))
        else begin
            $error("free_count %0d above the physical register count", free_count);
            failures++;
        end

    ok_tracks_count: assert property (@(posedge clock) disable iff (reset)
        alloc_ok == (free_count != '0))
        else begin
            $error("alloc_ok %0b does not match free_count %0d", alloc_ok, free_count);
            failures++;
        end

    // a restore may legally raise the count, so it is excluded
    empty_alloc_ignored: assert property (@(posedge clock) disable iff (reset)
        (alloc_req && !alloc_ok && !release_req && !restore_state) |=> $stable(free_count))
        else begin
            $error("allocation from an empty free list changed free_count");
            failures++;
        end

endmodule

bind rename_top rename_chk u_rename_chk (
    .clock         (clock),
    .reset         (reset),
    .alloc_req     (alloc_req),
    .release_req   (release_req),
    .restore_state (restore_state),
    .alloc_ok      (alloc_ok),
    .free_count    (free_count)
);

/* verif/rename_tb.sv */
`timescale 1ns/1ns
`include "rename_defs.svh"

module rename_tb;

    import rename_types_pkg::*;
    import ckpt_pkg::*;

    localparam int NUM_ROWS   = 30;
    localparam int CLK_PERIOD = 100;

    logic      clock;
    logic      reset;
    logic      alloc_req;
    phys_tag_t alloc_tag;
    logic      alloc_ok;
    logic      release_req;
    phys_tag_t release_tag;
    logic      save_state;
    ckpt_id_t  save_page;
    logic      restore_state;
    ckpt_id_t  restore_page;
    fl_count_t free_count;

    phys_tag_t m_mem [`RN_NUM_PHYS];    // model of the tag buffer
    fl_ptr_t   m_head;
    fl_ptr_t   m_tail;
    fl_ptr_t   m_saved [`RN_NUM_CKPT];  // model checkpoints
    logic      m_valid [`RN_NUM_CKPT];

    logic [31:0] ops [NUM_ROWS];  // expected count, repeats, op bits
    int          total_cycles;
    int          seed = 32'h6011;
    int          checks;
    int          errors;

    rename_top dut (
        .clock         (clock),
        .reset         (reset),
        .alloc_req     (alloc_req),
        .alloc_tag     (alloc_tag),
        .alloc_ok      (alloc_ok),
        .release_req   (release_req),
        .release_tag   (release_tag),
        .save_state    (save_state),
        .save_page     (save_page),
        .restore_state (restore_state),
        .restore_page  (restore_page),
        .free_count    (free_count)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    // row layout: [31:24] count at row start, [23:16] repeats, [12:3] ops
    function automatic logic [31:0] make_row(input int reps, input int a, input int r,
                                             input int s, input int sp, input int rs,
                                             input int rp, input int exp_count);
        make_row = {8'(exp_count), 8'(reps), 3'b000, 1'(a), 1'(r), 1'(s), 3'(sp),
                    1'(rs), 3'(rp), 3'b000};
    endfunction

    task automatic build_table();
        //                  rep al rl sv sp rs rp cnt
        ops[0]  = make_row(1,  0, 0, 0, 0, 0, 0, 96);   // idle after reset
        ops[1]  = make_row(5,  1, 0, 0, 0, 0, 0, 96);   // tags 32 onward
        ops[2]  = make_row(3,  0, 1, 0, 0, 0, 0, 91);
        ops[3]  = make_row(4,  1, 1, 0, 0, 0, 0, 94);   // count holds
        ops[4]  = make_row(1,  0, 0, 1, 2, 0, 0, 94);
        ops[5]  = make_row(6,  1, 0, 0, 0, 0, 0, 94);
        ops[6]  = make_row(2,  0, 1, 0, 0, 0, 0, 88);
        ops[7]  = make_row(1,  0, 0, 0, 0, 1, 2, 90);   // rewind to page 2
        ops[8]  = make_row(3,  1, 0, 0, 0, 0, 0, 96);   // same tags again
        ops[9]  = make_row(1,  0, 0, 0, 0, 1, 5, 93);   // page 5 not saved yet
        ops[10] = make_row(1,  0, 0, 1, 5, 0, 0, 93);
        ops[11] = make_row(2,  1, 0, 0, 0, 0, 0, 93);
        ops[12] = make_row(1,  0, 0, 1, 6, 0, 0, 91);
        ops[13] = make_row(1,  0, 0, 0, 0, 1, 5, 91);   // other valid page
        ops[14] = make_row(4,  1, 0, 0, 0, 0, 0, 93);
        ops[15] = make_row(1,  0, 0, 1, 3, 1, 2, 89);   // save during restore
        ops[16] = make_row(5,  1, 0, 0, 0, 0, 0, 96);
        ops[17] = make_row(1,  0, 0, 0, 0, 1, 3, 91);
        ops[18] = make_row(1,  1, 0, 0, 0, 1, 6, 96);   // restore beats alloc
        ops[19] = make_row(1,  0, 1, 0, 0, 1, 2, 91);
        ops[20] = make_row(97, 1, 0, 0, 0, 0, 0, 97);   // drain the list
        ops[21] = make_row(3,  1, 0, 0, 0, 0, 0, 0);
        ops[22] = make_row(1,  0, 1, 0, 0, 0, 0, 0);
        ops[23] = make_row(1,  0, 0, 0, 0, 0, 0, 1);    // released tag at head
        ops[24] = make_row(1,  1, 0, 0, 0, 0, 0, 1);
        ops[25] = make_row(8,  0, 1, 0, 0, 0, 0, 0);
        ops[26] = make_row(1,  1, 0, 0, 0, 0, 0, 8);
        ops[27] = make_row(1,  0, 0, 0, 0, 0, 0, 7);
        ops[28] = make_row(1,  0, 0, 0, 0, 1, 2, 7);
        ops[29] = make_row(2,  1, 0, 0, 0, 0, 0, 106);
        total_cycles = 0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            total_cycles += int'(ops[i][23:16]);
        end
    endtask

    task automatic model_reset();
        for (int i = 0; i < `RN_NUM_PHYS; i++) begin
            m_mem[i] = phys_tag_t'(i + `RN_NUM_ARCH);
        end
        for (int s = 0; s < `RN_NUM_CKPT; s++) begin
            m_saved[s] = '0;
            m_valid[s] = 1'b0;
        end
        m_head = '0;
        m_tail = fl_ptr_t'(`RN_NUM_PHYS - `RN_NUM_ARCH);
    endtask

    // random tag outside the free window as seen from the oldest checkpoint
    task automatic pick_release_tag(output logic found, output phys_tag_t tag);
        logic        reclaimable [`RN_NUM_PHYS];
        fl_ptr_t     base;
        fl_ptr_t     p;
        phys_tag_t   in_use [$];
        int unsigned r;
        base = m_head;
        for (int s = 0; s < `RN_NUM_CKPT; s++) begin
            if (m_valid[s] && fl_count_t'(m_tail - m_saved[s]) > fl_count_t'(m_tail - base)) begin
                base = m_saved[s];
            end
        end
        foreach (reclaimable[i]) begin
            reclaimable[i] = 1'b0;
        end
        for (p = base; p != m_tail; p++) begin
            reclaimable[m_mem[p[`RN_TAG_W-1:0]]] = 1'b1;
        end
        for (int t = 0; t < `RN_NUM_PHYS; t++) begin
            if (!reclaimable[t]) begin
                in_use.push_back(phys_tag_t'(t));
            end
        end
        found = (in_use.size() != 0);
        tag   = '0;
        if (found) begin
            r   = $unsigned($random(seed));
            tag = in_use[r % in_use.size()];
        end
    endtask

    task automatic check_outputs(input logic [7:0] exp_count, input logic anchor);
        phys_tag_t m_tag;
        fl_count_t m_count;
        m_tag   = m_mem[m_head[`RN_TAG_W-1:0]];
        m_count = fl_count_t'(m_tail - m_head);
        checks += 3;
        assert (alloc_tag == m_tag) else begin
            errors++;
            $display("Fail at %0t ns: alloc_tag %0d, expected %0d", $time, alloc_tag, m_tag);
        end
        assert (free_count == m_count) else begin
            errors++;
            $display("Fail at %0t ns: free_count %0d, expected %0d", $time, free_count, m_count);
        end
        assert (alloc_ok == (m_count != '0)) else begin
            errors++;
            $display("Fail at %0t ns: alloc_ok %0b with model count %0d", $time, alloc_ok,
                     m_count);
        end
        if (anchor) begin
            checks++;
            assert (free_count == exp_count) else begin
                errors++;
                $display("Fail at %0t ns: free_count %0d, table expects %0d", $time,
                         free_count, exp_count);
            end
        end
    endtask

    // one clock edge worth of the free list and checkpoint rules
    task automatic apply_model(input logic a, input logic r, input phys_tag_t tag,
                               input logic s, input ckpt_id_t sp, input logic rs,
                               input ckpt_id_t rp);
        logic    do_rewind;
        logic    do_alloc;
        fl_ptr_t target;
        do_rewind = rs && m_valid[rp];
        do_alloc  = a && (m_tail != m_head);
        target    = m_saved[rp];
        if (s) begin
            m_saved[sp] = do_rewind ? target : m_head;
            m_valid[sp] = 1'b1;
        end
        if (r) begin
            m_mem[m_tail[`RN_TAG_W-1:0]] = tag;
            m_tail = m_tail + fl_ptr_t'(1);
        end
        if (do_rewind) begin
            m_head = target;
        end else if (do_alloc) begin
            m_head = m_head + fl_ptr_t'(1);
        end
    endtask

    initial begin
        logic [31:0] row;
        logic        rel_ok;
        phys_tag_t   rel_tag;
        reset         = 1'b1;
        alloc_req     = 1'b0;
        release_req   = 1'b0;
        release_tag   = '0;
        save_state    = 1'b0;
        save_page     = '0;
        restore_state = 1'b0;
        restore_page  = '0;
        checks        = 0;
        errors        = 0;
        build_table();
        model_reset();
        repeat (10) @(posedge clock);
        reset <= 1'b0;
        for (int i = 0; i < NUM_ROWS; i++) begin
            row = ops[i];
            for (int k = 0; k < int'(row[23:16]); k++) begin
                @(posedge clock);
                rel_ok  = 1'b0;
                rel_tag = '0;
                if (row[11]) begin
                    pick_release_tag(rel_ok, rel_tag);
                end
                alloc_req     <= row[12];
                release_req   <= rel_ok;
                release_tag   <= rel_tag;
                save_state    <= row[10];
                save_page     <= ckpt_id_t'(row[9:7]);
                restore_state <= row[6];
                restore_page  <= ckpt_id_t'(row[5:3]);
                @(negedge clock);       // outputs settled, ops not yet clocked
                check_outputs(row[31:24], k == 0);
                apply_model(row[12], rel_ok, rel_tag, row[10], ckpt_id_t'(row[9:7]),
                            row[6], ckpt_id_t'(row[5:3]));
            end
        end
        @(posedge clock);
        alloc_req     <= 1'b0;
        release_req   <= 1'b0;
        save_state    <= 1'b0;
        restore_state <= 1'b0;
        @(negedge clock);
        check_outputs(8'hFF, 1'b0);
        $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
                 dut.u_rename_chk.failures);
        if (errors == 0 && dut.u_rename_chk.failures == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #1;  // table is filled at time zero
        #((total_cycles + 10 + 20) * CLK_PERIOD);
        $display("watchdog expired, the run took longer than the operation table allows");
        $display("Something failed");
        $finish;
    end

endmodule

/* src.f */
+incdir+include
src/rename_types_pkg.sv
src/ckpt_pkg.sv
src/ckpt_bank_if.sv
src/free_list.sv
src/ckpt_dispatch.sv
src/ckpt_slot.sv
src/ckpt_select.sv
src/rename_top.sv
verif/rename_chk.sv
verif/rename_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the rename testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module rename_tb \
    -Mdir obj_dir -o rename_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/rename_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation passed"
exit 0
